//--- vlog.f
+incdir+include
rtl/rename_pkg.sv
rtl/inst_decode.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/reorder_buffer.sv
rtl/rename_top.sv
dv/rename_tb.sv

//--- dv/rename_tb.sv
`include "rename_settings.svh"

module rename_tb
  import rename_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int N_SEQ        = 8;
  localparam int N_ZERO       = 8;
  localparam int N_MIX        = 24;
  localparam int N_FILL       = 20;
  localparam int N_REISSUE    = 6;
  localparam int N_ROLL       = 24;
  localparam int N_ISSUES     = N_SEQ + N_ZERO + N_MIX + N_FILL + N_REISSUE + N_ROLL;
  localparam int WATCHDOG_NS  =
    CLK_PERIOD * (RESET_CYCLES + 6 * N_ISSUES + 2 * `NUM_ROB * 8 + 200);
  localparam logic [6:0] OPC_REG = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;

  logic       clock;
  logic       reset;
  logic       inst_valid;
  inst_word_t inst;
  logic       retire_en;
  logic       rollback_en;
  logic       ren_valid;
  pr_idx_t    dest_pr;
  pr_idx_t    src1_pr;
  pr_idx_t    src2_pr;
  pr_idx_t    told_pr;
  logic       stall;

  int seed = 32'h62325b92;
  int errors = 0;
  int errors_at_start;
  int tests_run = 0;
  int tests_failed = 0;
  logic saw_stall;

  // ==============================
  // reference model state
  // ==============================
  pr_idx_t  m_spec [`NUM_AR];
  pr_idx_t  m_arch [`NUM_AR];
  pr_idx_t  m_free [`NUM_FL];
  fl_idx_t  m_head;
  fl_idx_t  m_tail;
  int       m_free_cnt;
  logic     m_dec_valid;
  ar_idx_t  m_dest;
  ar_idx_t  m_src1;
  ar_idx_t  m_src2;
  ar_idx_t  q_dest [$];
  pr_idx_t  q_t    [$];
  pr_idx_t  q_told [$];
  fl_idx_t  q_snap [$];
  logic     exp_ren_valid;
  logic     exp_stall;
  pr_idx_t  exp_dest;
  pr_idx_t  exp_src1;
  pr_idx_t  exp_src2;
  pr_idx_t  exp_told;

  rename_top dut0 (
    .clock, .reset, .inst_valid, .inst, .retire_en, .rollback_en,
    .ren_valid, .dest_pr, .src1_pr, .src2_pr, .told_pr, .stall
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  always @(posedge clock) begin : model_update
    pr_idx_t t;
    if (reset) begin
      for (int i = 0; i < `NUM_AR; i++) begin
        m_spec[i] = pr_idx_t'(i);
        m_arch[i] = pr_idx_t'(i);
      end
      for (int i = 0; i < `NUM_FL; i++) begin
        m_free[i] = pr_idx_t'(`NUM_AR + i);             // 32 up to 63 in order
      end
      m_head = '0;
      m_tail = '0;
      m_free_cnt = `NUM_FL;
      m_dec_valid = 1'b0;
      q_dest.delete();
      q_t.delete();
      q_told.delete();
      q_snap.delete();
      exp_ren_valid <= 1'b0;
      exp_stall <= 1'b0;
    end else begin
      t = (m_dest == `ZERO_REG) ? pr_idx_t'(`ZERO_PR) : m_free[m_tail];
      exp_ren_valid <= m_dec_valid && !rollback_en;
      exp_dest <= t;
      exp_src1 <= m_spec[m_src1];
      exp_src2 <= m_spec[m_src2];
      exp_told <= m_spec[m_dest];
      if (rollback_en) begin
        m_spec = m_arch;
        if (q_dest.size() > 0) begin
          m_tail = q_snap[0];                             // tail seen by the oldest unretired
        end
        foreach (q_dest[k]) begin
          if (q_dest[k] != `ZERO_REG) begin
            m_free_cnt++;
          end
        end
        q_dest.delete();
        q_t.delete();
        q_told.delete();
        q_snap.delete();
      end else begin
        if (retire_en && q_dest.size() > 0) begin
          if (q_told[0] != `ZERO_PR) begin
            m_free[m_head] = q_told[0];
            m_head++;
            m_free_cnt++;
          end
          if (q_dest[0] != `ZERO_REG) begin
            m_arch[q_dest[0]] = q_t[0];
          end
          void'(q_dest.pop_front());
          void'(q_t.pop_front());
          void'(q_told.pop_front());
          void'(q_snap.pop_front());
        end
        if (m_dec_valid) begin
          q_dest.push_back(m_dest);
          q_t.push_back(t);
          q_told.push_back(m_spec[m_dest]);
          q_snap.push_back(m_tail);
          if (m_dest != `ZERO_REG) begin
            m_spec[m_dest] = t;
            m_tail++;
            m_free_cnt--;
          end
        end
      end
      m_dec_valid = inst_valid && !rollback_en;
      m_dest = inst.r.rd;
      m_src1 = inst.i.rs1;
      m_src2 = (inst.r.opcode == OPC_REG) ? inst.r.rs2 : ar_idx_t'(`ZERO_REG);
      exp_stall <= (m_free_cnt < 2) || (q_dest.size() > `NUM_ROB - 2);
    end
  end

  task automatic note_mismatch(input string name, input int exp_val, input int act_val);
    errors++;
    $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp_val, act_val);
  endtask

  // ==============================
  // checks
  // ==============================
  a_ren_valid : assert property (@(posedge clock) disable iff (reset)
    ren_valid == exp_ren_valid)
    else note_mismatch("ren_valid", $sampled(exp_ren_valid), $sampled(ren_valid));
  a_dest_pr : assert property (@(posedge clock) disable iff (reset)
    ren_valid |-> dest_pr == exp_dest)
    else note_mismatch("dest_pr", $sampled(exp_dest), $sampled(dest_pr));
  a_src1_pr : assert property (@(posedge clock) disable iff (reset)
    ren_valid |-> src1_pr == exp_src1)
    else note_mismatch("src1_pr", $sampled(exp_src1), $sampled(src1_pr));
  a_src2_pr : assert property (@(posedge clock) disable iff (reset)
    ren_valid |-> src2_pr == exp_src2)
    else note_mismatch("src2_pr", $sampled(exp_src2), $sampled(src2_pr));
  a_told_pr : assert property (@(posedge clock) disable iff (reset)
    ren_valid |-> told_pr == exp_told)
    else note_mismatch("told_pr", $sampled(exp_told), $sampled(told_pr));
  a_stall : assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
    else note_mismatch("stall", $sampled(exp_stall), $sampled(stall));

  function automatic inst_word_t make_inst(input ar_idx_t rd, input ar_idx_t rs1,
                                           input ar_idx_t rs2, input logic reg_fmt);
    inst_word_t w;
    w = inst_word_t'($random(seed));
    w.r.rd = rd;
    w.r.rs1 = rs1;
    w.r.rs2 = rs2;                                        // immediate bits in the other format
    w.r.opcode = reg_fmt ? OPC_REG : OPC_IMM;
    return w;
  endfunction

  function automatic inst_word_t random_inst(input logic allow_zero_rd);
    ar_idx_t rd;
    rd = ar_idx_t'($random(seed));
    if (!allow_zero_rd && rd == `ZERO_REG) begin
      rd = 1;
    end
    return make_inst(rd, ar_idx_t'($random(seed)), ar_idx_t'($random(seed)),
                     $random(seed) & 1);
  endfunction

  task automatic drive(input logic iv, input inst_word_t w, input logic ret, input logic rb);
    @(posedge clock);
    inst_valid <= iv;
    inst <= w;
    retire_en <= ret;
    rollback_en <= rb;
  endtask

  // the idle cycle before each issue keeps a slot of margin over the stall level
  task automatic issue(input inst_word_t w);
    drive(1'b0, w, 1'b0, 1'b0);
    while (stall) begin
      saw_stall = 1'b1;
      drive(1'b0, w, 1'b1, 1'b0);                         // retire until there is room
      drive(1'b0, w, 1'b0, 1'b0);
    end
    drive(1'b1, w, 1'b0, 1'b0);
  endtask

  task automatic drain();
    repeat (3) drive(1'b0, '0, 1'b0, 1'b0);
  endtask

  task automatic retire_all();
    repeat (`NUM_ROB) begin
      drive(1'b0, '0, 1'b1, 1'b0);
      drive(1'b0, '0, 1'b0, 1'b0);
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
    end
    $display("test %-14s %0d errors", name, errors - errors_at_start);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  initial begin
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    retire_en = 1'b0;
    rollback_en = 1'b0;
    saw_stall = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    start_test();
    for (int i = 1; i <= N_SEQ; i++) begin
      issue(make_inst(ar_idx_t'(i), ar_idx_t'(i - 1), ar_idx_t'(i + 8), 1'b1));
    end
    drain();
    retire_all();
    finish_test("alloc_order");

    start_test();
    for (int i = 0; i < N_ZERO; i++) begin
      issue(make_inst((i % 2) ? ar_idx_t'(`ZERO_REG) : ar_idx_t'(i + 3),
                      ar_idx_t'(i + 3), ar_idx_t'(0), 1'b1));
    end
    drain();
    retire_all();
    finish_test("zero_dest");

    start_test();
    for (int i = 0; i < N_MIX; i++) begin
      issue(random_inst(1'b1));
      if ($random(seed) % 4 == 0) begin
        drive(1'b0, '0, 1'b1, 1'b0);
      end
    end
    drain();
    retire_all();
    finish_test("source_map");

    start_test();
    saw_stall = 1'b0;
    for (int i = 0; i < N_FILL; i++) begin
      issue(random_inst(1'b0));
    end
    if (!saw_stall) begin
      errors++;
      $display("stall never rose while the reorder buffer was filling up");
    end
    drain();
    retire_all();
    for (int i = 0; i < N_REISSUE; i++) begin
      issue(random_inst(1'b0));                           // freed registers come back in order
    end
    drain();
    retire_all();
    finish_test("stall_retire");

    start_test();
    for (int i = 0; i < 6; i++) begin
      issue(random_inst(1'b0));
    end
    drain();
    repeat (2) begin
      drive(1'b0, '0, 1'b1, 1'b0);
      drive(1'b0, '0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      issue(random_inst(1'b1));
    end
    drive(1'b0, '0, 1'b0, 1'b1);                          // last word is still in decode
    drive(1'b0, '0, 1'b0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      issue(random_inst(1'b1));
    end
    drain();
    drive(1'b0, '0, 1'b1, 1'b1);                          // flush and retire together
    drive(1'b0, '0, 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      issue(random_inst(1'b0));
    end
    drain();
    retire_all();
    drive(1'b0, '0, 1'b0, 1'b1);                          // flush with nothing in flight
    drive(1'b0, '0, 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      issue(random_inst(1'b1));
    end
    drain();
    retire_all();
    finish_test("rollback");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- rtl/rename_top.sv
module rename_top
  import rename_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       inst_valid,
  input  inst_word_t inst,
  input  logic       retire_en,
  input  logic       rollback_en,
  output logic       ren_valid,
  output pr_idx_t    dest_pr,
  output pr_idx_t    src1_pr,
  output pr_idx_t    src2_pr,
  output pr_idx_t    told_pr,
  output logic       stall
);

  logic    dec_valid;
  ar_idx_t dec_dest;
  ar_idx_t dec_src1;
  ar_idx_t dec_src2;
  pr_idx_t t_idx;
  pr_idx_t map_src1_pr;
  pr_idx_t map_src2_pr;
  pr_idx_t map_told;
  fl_idx_t alloc_tail;
  logic    free_low;
  logic    retire_valid;
  ar_idx_t retire_dest;
  pr_idx_t retire_t;
  pr_idx_t retire_told;
  fl_idx_t rollback_idx;
  logic    rob_near_full;

  inst_decode u_decode (
    .clock, .reset, .inst_valid, .inst, .rollback_en,
    .dec_valid, .dec_dest, .dec_src1, .dec_src2
  );

  map_table u_map (
    .clock, .reset, .rollback_en, .dec_valid, .dec_dest, .dec_src1, .dec_src2, .t_idx,
    .retire_valid, .retire_dest, .retire_t,
    .src1_pr(map_src1_pr), .src2_pr(map_src2_pr), .told(map_told)
  );

  free_list u_free (
    .clock, .reset, .dec_valid, .dec_dest, .retire_valid, .retire_told,
    .rollback_en, .rollback_idx, .t_idx, .alloc_tail, .free_low
  );

  reorder_buffer u_rob (
    .clock, .reset, .dec_valid, .dec_dest, .t_idx, .told(map_told), .alloc_tail,
    .retire_en, .rollback_en, .retire_valid, .retire_dest, .retire_t, .retire_told,
    .rollback_idx, .rob_near_full
  );

  // ==============================
  // rename output stage
  // ==============================
  always_ff @(posedge clock) begin
    if (reset) begin
      ren_valid <= 1'b0;
    end else begin
      ren_valid <= dec_valid && !rollback_en;      // flushed renames never show up
    end
  end

  always_ff @(posedge clock) begin
    dest_pr <= t_idx;
    src1_pr <= map_src1_pr;
    src2_pr <= map_src2_pr;
    told_pr <= map_told;
  end

  assign stall = free_low || rob_near_full;        // leaves room for the word already in decode

endmodule

//--- rtl/reorder_buffer.sv
`include "rename_settings.svh"

module reorder_buffer
  import rename_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    dec_valid,
  input  ar_idx_t dec_dest,
  input  pr_idx_t t_idx,
  input  pr_idx_t told,
  input  fl_idx_t alloc_tail,
  input  logic    retire_en,
  input  logic    rollback_en,
  output logic    retire_valid,
  output ar_idx_t retire_dest,
  output pr_idx_t retire_t,
  output pr_idx_t retire_told,
  output fl_idx_t rollback_idx,
  output logic    rob_near_full
);

  localparam int unsigned CNT_W = $clog2(`NUM_ROB + 1);

  ar_idx_t          dest_mem [`NUM_ROB];
  pr_idx_t          t_mem    [`NUM_ROB];
  pr_idx_t          told_mem [`NUM_ROB];
  fl_idx_t          tail_mem [`NUM_ROB];
  rob_idx_t         head;
  rob_idx_t         tail;
  logic [CNT_W-1:0] count;
  logic             empty;
  logic             push;
  logic             pop;

  assign empty = count == '0;
  assign push  = dec_valid && !rollback_en;
  assign pop   = retire_en && !empty && !rollback_en;   // a flush beats a retire

  assign retire_valid = pop;
  assign retire_dest  = dest_mem[head];
  assign retire_t     = t_mem[head];
  assign retire_told  = told_mem[head];

  // oldest unretired entry holds the tail it saw before allocating
  assign rollback_idx  = empty ? alloc_tail : tail_mem[head];
  assign rob_near_full = count > (`NUM_ROB - 2);

  // ==============================
  // pointers and occupancy
  // ==============================
  always_ff @(posedge clock) begin
    if (reset || rollback_en) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      dest_mem[tail] <= dec_dest;
      t_mem[tail]    <= t_idx;
      told_mem[tail] <= told;
      tail_mem[tail] <= alloc_tail;
    end
  end

  // back-pressure from the top must stop renames before the buffer fills
  a_no_push_when_full : assert property (
    @(posedge clock) disable iff (reset) push |-> count != CNT_W'(`NUM_ROB));

endmodule

//--- rtl/free_list.sv
`include "rename_settings.svh"

module free_list
  import rename_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    dec_valid,
  input  ar_idx_t dec_dest,
  input  logic    retire_valid,
  input  pr_idx_t retire_told,
  input  logic    rollback_en,
  input  fl_idx_t rollback_idx,
  output pr_idx_t t_idx,
  output fl_idx_t alloc_tail,
  output logic    free_low
);

  localparam int unsigned CNT_W = $clog2(`NUM_FL + 1);

  pr_idx_t          fl_table [`NUM_FL];
  fl_idx_t          head;
  fl_idx_t          tail;
  logic [CNT_W-1:0] free_cnt;
  logic             alloc;
  logic             recycle;

  assign alloc   = dec_valid && dec_dest != `ZERO_REG && !rollback_en;
  assign recycle = retire_valid && retire_told != `ZERO_PR;

  assign t_idx      = (dec_dest == `ZERO_REG) ? pr_idx_t'(`ZERO_PR) : fl_table[tail];
  assign alloc_tail = tail;                        // saved in the rob as the rollback point
  assign free_low   = free_cnt < 2;

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      free_cnt <= CNT_W'(`NUM_FL);
      for (int i = 0; i < `NUM_FL; i++) begin
        fl_table[i] <= pr_idx_t'(i + `NUM_AR);
      end
    end else begin
      if (recycle) begin
        fl_table[head] <= retire_told;
        head           <= head + 1'b1;
      end
      if (rollback_en) begin
        tail     <= rollback_idx;
        free_cnt <= CNT_W'(`NUM_FL);                // nothing stays in flight after a flush
      end else begin
        if (alloc) begin
          tail <= tail + 1'b1;
        end
        if (alloc && !recycle) begin
          free_cnt <= free_cnt - 1'b1;
        end else if (recycle && !alloc) begin
          free_cnt <= free_cnt + 1'b1;
        end
      end
    end
  end

  // stall has to hold the source off before the list runs dry
  a_no_alloc_when_empty : assert property (
    @(posedge clock) disable iff (reset) alloc |-> free_cnt != '0);

endmodule

//--- rtl/map_table.sv
`include "rename_settings.svh"

module map_table
  import rename_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    rollback_en,
  input  logic    dec_valid,
  input  ar_idx_t dec_dest,
  input  ar_idx_t dec_src1,
  input  ar_idx_t dec_src2,
  input  pr_idx_t t_idx,
  input  logic    retire_valid,
  input  ar_idx_t retire_dest,
  input  pr_idx_t retire_t,
  output pr_idx_t src1_pr,
  output pr_idx_t src2_pr,
  output pr_idx_t told
);

  pr_idx_t spec_map [`NUM_AR];
  pr_idx_t arch_map [`NUM_AR];
  logic    spec_wr;
  logic    arch_wr;

  // register zero never gets a new mapping
  assign spec_wr = dec_valid && dec_dest != `ZERO_REG;
  assign arch_wr = retire_valid && retire_dest != `ZERO_REG;

  assign src1_pr = spec_map[dec_src1];
  assign src2_pr = spec_map[dec_src2];
  assign told    = spec_map[dec_dest];             // mapping being replaced, freed at retire

  // ==============================
  // speculative map
  // ==============================
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_AR; i++) begin
        spec_map[i] <= pr_idx_t'(i);
      end
      spec_map[`ZERO_REG] <= pr_idx_t'(`ZERO_PR);
    end else if (rollback_en) begin
      spec_map <= arch_map;                         // back to the last retired state
    end else if (spec_wr) begin
      spec_map[dec_dest] <= t_idx;
    end
  end

  // ==============================
  // architectural map
  // ==============================
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_AR; i++) begin
        arch_map[i] <= pr_idx_t'(i);
      end
      arch_map[`ZERO_REG] <= pr_idx_t'(`ZERO_PR);
    end else if (arch_wr) begin
      arch_map[retire_dest] <= retire_t;
    end
  end

endmodule

//--- rtl/inst_decode.sv
`include "rename_settings.svh"

module inst_decode
  import rename_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       inst_valid,
  input  inst_word_t inst,
  input  logic       rollback_en,
  output logic       dec_valid,
  output ar_idx_t    dec_dest,
  output ar_idx_t    dec_src1,
  output ar_idx_t    dec_src2
);

  localparam logic [6:0] OPC_REG = 7'b0110011;   // register-register alu group

  inst_word_t inst_q;
  logic       valid_q;
  logic       is_reg_fmt;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= inst_valid && !rollback_en;     // a flush also drops the word arriving now
    end
  end

  always_ff @(posedge clock) begin
    inst_q <= inst;
  end

  assign is_reg_fmt = inst_q.r.opcode == OPC_REG;

  assign dec_valid = valid_q;
  assign dec_dest  = inst_q.r.rd;
  assign dec_src1  = inst_q.i.rs1;
  assign dec_src2  = is_reg_fmt ? inst_q.r.rs2 : ar_idx_t'(`ZERO_REG);   // immediate bits otherwise

  // the source may only start issuing once reset has been released
  a_no_inst_in_reset : assert property (@(posedge clock) reset |-> !inst_valid);

endmodule

//--- rtl/rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

  typedef logic [$clog2(`NUM_AR)-1:0]  ar_idx_t;
  typedef logic [$clog2(`NUM_PR)-1:0]  pr_idx_t;
  typedef logic [$clog2(`NUM_FL)-1:0]  fl_idx_t;
  typedef logic [$clog2(`NUM_ROB)-1:0] rob_idx_t;

  // ==============================
  // instruction word views
  // ==============================
  typedef struct packed {
    logic [6:0] funct7;
    ar_idx_t    rs2;
    ar_idx_t    rs1;
    logic [2:0] funct3;
    ar_idx_t    rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;                 // covers the rs2 field of the register format
    ar_idx_t     rs1;
    logic [2:0]  funct3;
    ar_idx_t     rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // decode picks the view by opcode
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_word_t;

endpackage

//--- include/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// ==============================
// register file sizes
// ==============================
`define NUM_PR   64
`define NUM_AR   32
`define NUM_FL   (`NUM_PR - `NUM_AR)

// ==============================
// in-flight window and zero register
// ==============================
`define NUM_ROB  16
`define ZERO_REG 0
`define ZERO_PR  0

`endif
